// File: bench/tb_ice_controller.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ice_controller;

	import ice_pkg::*;

	localparam int tb_cpb = 8;
	localparam int cycle_limit = 40000;

	logic clk;
	logic reset;
	logic usb_uart_txd;
	logic pint_rdrdy;
	logic pint_rddata;
	wire  usb_uart_rxd;
	wire  pint_wrreq;
	wire  pint_wrdata;
	wire  pint_clk;
	wire  pint_resetn;
	wire  pint_rdreq;

	int         errors = 0;
	int         cycles = 0;
	int         seed = 40;
	pint_req_t  exp_q[$];
	pint_req_t  cap_q[$];
	int         cap_len_q[$];
	logic [7:0] host_rx[$];
	logic [7:0] resp [0:5];

	ice_controller #(.clks_per_bit(tb_cpb)) i_dut (
		.clk(clk), .reset(reset),
		.usb_uart_txd(usb_uart_txd), .usb_uart_rxd(usb_uart_rxd),
		.pint_wrreq(pint_wrreq), .pint_wrdata(pint_wrdata), .pint_clk(pint_clk),
		.pint_resetn(pint_resetn), .pint_rdreq(pint_rdreq),
		.pint_rdrdy(pint_rdrdy), .pint_rddata(pint_rddata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run stopped: no result after %0d clock cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic flag_mismatch(input string name, input logic [63:0] expected,
	                             input logic [63:0] actual);
		errors++;
		$display("[ERROR] time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
	                           input logic [63:0] actual);
		assert (actual === expected) else flag_mismatch(name, expected, actual);
	endtask

	// Host side of the UART sends 8N1 LSB first
	task automatic send_char(input logic [7:0] c);
		logic [9:0] frame;
		int b;
		frame = {1'b1, c, 1'b0};
		for (b = 0; b < 10; b++) begin
			@(posedge clk);
			#1 usb_uart_txd = frame[b];
			repeat (tb_cpb - 1) @(posedge clk);
		end
	endtask

	task automatic send_line(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			send_char(s[i]);
	endtask

	task automatic expect_frame(input logic cmd_type, input logic [2:0] num,
	                            input logic [39:0] data);
		pint_req_t f;
		f.cmd_type = cmd_type;
		f.num_bytes = num;
		f.data = data;
		exp_q.push_back(f);
	endtask

	task automatic check_frames();
		pint_req_t e;
		pint_req_t c;
		int len;
		while (cap_q.size() < exp_q.size())
			@(negedge clk);
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			c = cap_q.pop_front();
			len = cap_len_q.pop_front();
			check_value("frame cmd_type", 64'(e.cmd_type), 64'(c.cmd_type));
			check_value("frame num_bytes", 64'(e.num_bytes), 64'(c.num_bytes));
			check_value("frame data", 64'(e.data), 64'(c.data));
			check_value("frame bit count", 64'(4 + 8 * e.num_bytes), 64'(len));
		end
	endtask

	// Report holds 'a', the first n bytes of resp[] and a newline
	task automatic check_report(input int n);
		int i;
		while (host_rx.size() < n + 2)
			@(negedge clk);
		check_value("report ack char", 64'h61, 64'(host_rx.pop_front()));
		for (i = 0; i < n; i++)
			check_value("report data byte", 64'(resp[i]), 64'(host_rx.pop_front()));
		check_value("report end char", 64'h0a, 64'(host_rx.pop_front()));
	endtask

	// Chip answers with resp[] one bit per PINT_CLK rising edge
	task automatic play_read(input int n);
		int k;
		@(posedge clk);
		#1;
		pint_rdrdy = 1'b1;
		pint_rddata = resp[0][7];
		for (k = 0; k < 8 * n; k++) begin
			do begin
				@(posedge clk);
				#1;
			end while (!(pint_rdreq === 1'b1 && pint_clk === 1'b1));
			if (k + 1 < 8 * n) begin
				pint_rddata = resp[(k + 1) / 8][7 - ((k + 1) % 8)];
			end else begin
				// Link may stop at this byte boundary
				pint_rdrdy = 1'b0;
				pint_rddata = 1'b0;
			end
		end
	endtask

	initial begin : uart_monitor
		logic [7:0] c;
		int k;
		forever begin
			@(negedge clk);
			if (reset === 1'b0 && usb_uart_rxd === 1'b0) begin
				// Go to the middle of the start bit and step one bit period per sample
				repeat (tb_cpb / 2) @(negedge clk);
				for (k = 0; k < 8; k++) begin
					repeat (tb_cpb) @(negedge clk);
					c[k] = usb_uart_rxd;
				end
				repeat (tb_cpb) @(negedge clk);
				check_value("usb_uart_rxd stop bit", 64'd1, 64'(usb_uart_rxd));
				host_rx.push_back(c);
			end
		end
	end

	initial begin : chip_capture
		logic fb [0:63];
		int nbits;
		int i;
		logic last_clk;
		logic last_req;
		pint_req_t f;
		nbits = 0;
		last_clk = 1'b0;
		last_req = 1'b0;
		forever begin
			@(negedge clk);
			if (pint_wrreq === 1'b1 && pint_clk === 1'b1 && !last_clk) begin
				if (nbits < 64)
					fb[nbits] = pint_wrdata;
				nbits++;
			end
			if (pint_wrreq === 1'b0 && last_req === 1'b1) begin
				// cmd_type, num_bytes MSB first, then data MSB first
				f = '0;
				f.cmd_type = fb[0];
				f.num_bytes = {fb[1], fb[2], fb[3]};
				for (i = 4; i < nbits && i < 44; i++)
					f.data[43 - i] = fb[i];
				cap_q.push_back(f);
				cap_len_q.push_back(nbits);
				nbits = 0;
			end
			last_clk = pint_clk;
			last_req = pint_wrreq;
		end
	end

	wrdata_quiet: assert property (@(posedge clk) disable iff (reset)
		!pint_wrreq |-> !pint_wrdata)
		else flag_mismatch("pint_wrdata", 64'd0, 64'(pint_wrdata));

	one_direction: assert property (@(posedge clk) disable iff (reset)
		!(pint_wrreq && pint_rdreq))
		else flag_mismatch("pint_rdreq", 64'd0, 64'(pint_rdreq));

	clk_parked: assert property (@(posedge clk) disable iff (reset)
		(!pint_wrreq && !pint_rdreq) |-> !pint_clk)
		else flag_mismatch("pint_clk", 64'd0, 64'(pint_clk));

	chip_in_reset: assert property (@(posedge clk) reset |=> !pint_resetn)
		else flag_mismatch("pint_resetn", 64'd0, 64'(pint_resetn));

	chip_running: assert property (@(posedge clk) !reset |=> pint_resetn)
		else flag_mismatch("pint_resetn", 64'd1, 64'(pint_resetn));

	initial begin : stimulus
		logic [39:0] d;
		logic [7:0] b;
		string line;
		int n;
		int i;
		int j;
		reset = 1'b1;
		usb_uart_txd = 1'b1;
		pint_rdrdy = 1'b0;
		pint_rddata = 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("pint_resetn", 64'd0, 64'(pint_resetn));
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("usb_uart_rxd", 64'd1, 64'(usb_uart_rxd));
		check_value("pint_wrreq", 64'd0, 64'(pint_wrreq));
		check_value("pint_rdreq", 64'd0, 64'(pint_rdreq));
		check_value("pint_clk", 64'd0, 64'(pint_clk));
		check_value("pint_resetn", 64'd1, 64'(pint_resetn));

		send_line("wA5c3\n");
		expect_frame(1'b0, 3'd2, {16'hA5C3, 24'h0});
		check_frames();

		// Odd last digit dropped and an empty line sends nothing
		send_line("r123\n");
		expect_frame(1'b1, 3'd1, {8'h12, 32'h0});
		check_frames();
		send_line("r\n");

		// Second letter aborts the partial line
		send_line("w12");
		send_line("w3456\n");
		expect_frame(1'b0, 3'd2, {16'h3456, 24'h0});
		check_frames();

		for (i = 0; i < 3; i++)
			resp[i] = 8'($random(seed));
		play_read(3);
		check_report(3);

		// Random writes in mixed hex case
		for (i = 0; i < 5; i++) begin
			n = 1 + int'($unsigned($random(seed)) % 5);
			d = '0;
			line = "w";
			for (j = 0; j < n; j++) begin
				b = 8'($random(seed));
				d[39 - 8 * j -: 8] = b;
				if (i % 2 == 0)
					line = {line, $sformatf("%02X", b)};
				else
					line = {line, $sformatf("%02x", b)};
			end
			send_line(line);
			if (i == 2) begin
				// Chip streams across the newline so the request waits for busy
				for (j = 0; j < 6; j++)
					resp[j] = 8'($random(seed));
				fork
					send_char(8'h0a);
					play_read(6);
				join
			end else begin
				send_char(8'h0a);
			end
			expect_frame(1'b0, 3'(n), d);
		end
		check_frames();
		check_report(6);

		check_value("extra frames", 64'd0, 64'(cap_q.size()));
		check_value("extra report chars", 64'd0, 64'(host_rx.size()));

		$display("Checks complete after %0d cycles with %0d error(s)", cycles, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
verilog/ice_pkg.sv
verilog/uart.sv
verilog/char_decoder.sv
verilog/byte_fifo.sv
verilog/pint_link.sv
verilog/ice_controller.sv
bench/tb_ice_controller.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_ice_controller -f build.f

./obj_dir/Vtb_ice_controller | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi

// File: verilog/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo (
	input  wire        clk,
	input  wire        reset,
	input  wire  [7:0] in_data,
	input  wire        push,
	output logic [7:0] out_data,
	input  wire        pop,
	output logic       out_valid
);

	import ice_pkg::*;

	logic [7:0]                 mem [2**fifo_depth_log2];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	logic [fifo_depth_log2:0]   count;
	logic                       full;
	logic                       do_push;
	logic                       do_pop;

	// Count reaches the top bit only when full
	assign full = count[fifo_depth_log2];
	assign out_valid = (count != '0);
	assign do_push = push && !full;
	assign do_pop = pop && out_valid;

	// Head of the queue is always on the output
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + (fifo_depth_log2)'(do_push);
			rd_ptr <= rd_ptr + (fifo_depth_log2)'(do_pop);
			count <= count + (fifo_depth_log2 + 1)'(do_push) - (fifo_depth_log2 + 1)'(do_pop);
		end
	end

	no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
		else $error("byte_fifo: push while full, byte dropped");

	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop && !out_valid))
		else $error("byte_fifo: pop while empty");

endmodule

`default_nettype wire

// File: verilog/char_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module char_decoder (
	input  wire  [7:0]                in_char,
	input  wire                       in_valid,
	output ice_pkg::char_class_t      cls
);

	import ice_pkg::*;

	always_comb begin
		cls = '0;
		if (in_valid) begin
			if (in_char >= "0" && in_char <= "9") begin
				cls.is_hex = 1'b1;
				cls.hex = in_char[3:0];
			end else if ((in_char >= "a" && in_char <= "f") ||
			             (in_char >= "A" && in_char <= "F")) begin
				// Both cases share the low nibble, 1 for a/A
				cls.is_hex = 1'b1;
				cls.hex = in_char[3:0] + 4'd9;
			end

			case (in_char)
				"w": begin
					cls.is_cmd = 1'b1;
					cls.cmd = cmd_write;
				end
				"r": begin
					cls.is_cmd = 1'b1;
					cls.cmd = cmd_read;
				end
				8'h0a: cls.is_eol = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/ice_controller.sv
`timescale 1ns/100ps
`default_nettype none

module ice_controller #(
	parameter int clks_per_bit = ice_pkg::clks_per_bit_default
) (
	input  wire clk,
	input  wire reset,
	input  wire usb_uart_txd,
	output wire usb_uart_rxd,
	output wire pint_wrreq,
	output wire pint_wrdata,
	output wire pint_clk,
	output wire pint_resetn,
	output wire pint_rdreq,
	input  wire pint_rdrdy,
	input  wire pint_rddata
);

	import ice_pkg::*;

	typedef enum logic [1:0] {cmd_idle, cmd_collect, cmd_pad, cmd_issue} cmd_state_t;
	typedef enum logic [1:0] {rep_idle, rep_ack, rep_data, rep_eol} rep_state_t;

	logic [7:0]  rx_data;
	logic        rx_latch;
	logic [7:0]  tx_data;
	logic        tx_latch;
	logic        tx_empty;
	char_class_t cls;
	pint_req_t   req;
	logic        req_latch;
	logic        busy;
	logic [7:0]  fifo_data;
	logic        fifo_push;
	logic        rx_done;
	logic [7:0]  out_data;
	logic        out_valid;
	logic        pop;
	cmd_state_t  cmd_state;
	rep_state_t  rep_state;
	logic [39:0] hex_sr;
	logic [3:0]  digit_cnt;
	logic [2:0]  num_bytes;
	logic        is_read;
	logic [5:0]  pad_shift;

	uart #(.clks_per_bit(clks_per_bit)) i_uart (
		.clk(clk), .reset(reset),
		.rx_in(usb_uart_txd), .tx_out(usb_uart_rxd),
		.tx_latch(tx_latch), .tx_data(tx_data), .tx_empty(tx_empty),
		.rx_data(rx_data), .rx_latch(rx_latch)
	);

	char_decoder i_decoder (.in_char(rx_data), .in_valid(rx_latch), .cls(cls));

	byte_fifo i_fifo (
		.clk(clk), .reset(reset),
		.in_data(fifo_data), .push(fifo_push),
		.out_data(out_data), .pop(pop), .out_valid(out_valid)
	);

	pint_link i_pint (
		.clk(clk), .reset(reset),
		.req(req), .req_latch(req_latch), .busy(busy),
		.fifo_data(fifo_data), .fifo_push(fifo_push), .rx_done(rx_done),
		.pint_wrreq(pint_wrreq), .pint_wrdata(pint_wrdata), .pint_clk(pint_clk),
		.pint_resetn(pint_resetn), .pint_rdreq(pint_rdreq),
		.pint_rdrdy(pint_rdrdy), .pint_rddata(pint_rddata)
	);

	// Zero nibbles needed to left-justify the digits
	assign pad_shift = {4'(max_digits) - digit_cnt, 2'b00};

	assign req = '{cmd_type: is_read, num_bytes: num_bytes, data: hex_sr};
	assign req_latch = (cmd_state == cmd_pad || cmd_state == cmd_issue) &&
	                   num_bytes != 3'd0 && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_state <= cmd_idle;
			digit_cnt <= '0;
		end else if (cls.is_cmd) begin
			// A new letter drops any partial line
			cmd_state <= cmd_collect;
			digit_cnt <= '0;
			is_read <= (cls.cmd == cmd_read);
		end else begin
			case (cmd_state)
				cmd_collect: begin
					if (cls.is_hex && digit_cnt < 4'(max_digits)) begin
						hex_sr <= {hex_sr[35:0], cls.hex};
						digit_cnt <= digit_cnt + 4'd1;
					end else if (cls.is_eol) begin
						hex_sr <= hex_sr << pad_shift;
						// Odd trailing digit is not sent
						num_bytes <= digit_cnt[3:1];
						cmd_state <= cmd_pad;
					end
				end
				cmd_pad: cmd_state <= (num_bytes == 3'd0 || !busy) ? cmd_idle : cmd_issue;
				cmd_issue: begin
					if (!busy)
						cmd_state <= cmd_idle;
				end
				default: ;
			endcase
		end
	end

	// Report is 'a', every buffered byte, then newline
	always_comb begin
		tx_latch = 1'b0;
		tx_data = 8'h00;
		pop = 1'b0;
		case (rep_state)
			rep_ack: begin
				tx_latch = tx_empty;
				tx_data = "a";
			end
			rep_data: begin
				tx_latch = tx_empty && out_valid;
				tx_data = out_data;
				pop = tx_latch;
			end
			rep_eol: begin
				tx_latch = tx_empty;
				tx_data = 8'h0a;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rep_state <= rep_idle;
		end else begin
			case (rep_state)
				rep_idle: if (rx_done) rep_state <= rep_ack;
				rep_ack: if (tx_empty) rep_state <= rep_data;
				rep_data: if (!out_valid) rep_state <= rep_eol;
				default: if (tx_empty) rep_state <= rep_idle;
			endcase
		end
	end

	tx_accepted: assert property (@(posedge clk) disable iff (reset) tx_latch |=> !tx_empty)
		else $error("ice_controller: UART transmitter ignored tx_latch");

endmodule

`default_nettype wire

// File: verilog/ice_pkg.sv
`default_nettype none

package ice_pkg;

	// 20 MHz clock into 115200 baud
	localparam int clks_per_bit_default = 174;

	// Read FIFO of 16 bytes
	localparam int fifo_depth_log2 = 4;

	// Five bytes per request
	localparam int max_digits = 10;

	localparam logic [3:0] cmd_write = 4'd0;
	localparam logic [3:0] cmd_read = 4'd1;

	// Meaning of one received character
	typedef struct packed {
		logic       is_hex;
		logic [3:0] hex;
		logic       is_cmd;
		logic [3:0] cmd;
		logic       is_eol;
	} char_class_t;

	// One outgoing frame, first byte in data[39:32]
	typedef struct packed {
		logic        cmd_type;
		logic [2:0]  num_bytes;
		logic [39:0] data;
	} pint_req_t;

endpackage

`default_nettype wire

// File: verilog/pint_link.sv
`timescale 1ns/100ps
`default_nettype none

module pint_link (
	input  wire                clk,
	input  wire                reset,
	input  wire ice_pkg::pint_req_t req,
	input  wire                req_latch,
	output logic               busy,
	output logic [7:0]         fifo_data,
	output logic               fifo_push,
	output logic               rx_done,
	output logic               pint_wrreq,
	output logic               pint_wrdata,
	output logic               pint_clk,
	output logic               pint_resetn,
	output logic               pint_rdreq,
	input  wire                pint_rdrdy,
	input  wire                pint_rddata
);

	import ice_pkg::*;

	logic                         tx_active;
	logic                         rx_active;
	logic [$bits(pint_req_t)-1:0] tx_shift;
	logic [5:0]                   tx_bits;
	logic [2:0]                   rx_bit;
	logic [7:0]                   rx_shift;

	assign busy = tx_active || rx_active;
	assign pint_wrreq = tx_active;
	assign pint_wrdata = tx_active && tx_shift[$bits(pint_req_t)-1];
	assign pint_rdreq = rx_active;
	assign fifo_data = rx_shift;

	// Chip reset follows ours, one cycle late
	always_ff @(posedge clk) begin
		pint_resetn <= !reset;
	end

	// PINT_CLK runs at clk/2, only while a transfer is active
	always_ff @(posedge clk) begin
		fifo_push <= 1'b0;
		rx_done <= 1'b0;
		if (reset) begin
			tx_active <= 1'b0;
			rx_active <= 1'b0;
			pint_clk <= 1'b0;
			tx_bits <= '0;
			rx_bit <= '0;
		end else if (req_latch) begin
			tx_active <= 1'b1;
			pint_clk <= 1'b0;
			tx_shift <= req;
			// cmd_type plus num_bytes, then the bytes
			tx_bits <= 6'd4 + {req.num_bytes, 3'b000};
		end else if (tx_active) begin
			pint_clk <= !pint_clk;
			if (pint_clk) begin
				tx_shift <= tx_shift << 1;
				tx_bits <= tx_bits - 6'd1;
				if (tx_bits == 6'd1)
					tx_active <= 1'b0;
			end
		end else if (rx_active) begin
			if (pint_clk) begin
				pint_clk <= 1'b0;
			end else if (rx_bit == 3'd0 && !pint_rdrdy) begin
				// Chip is done, only checked between bytes
				rx_active <= 1'b0;
				rx_done <= 1'b1;
			end else begin
				pint_clk <= 1'b1;
				rx_shift <= {rx_shift[6:0], pint_rddata};
				rx_bit <= rx_bit + 3'd1;
				fifo_push <= (rx_bit == 3'd7);
			end
		end else if (pint_rdrdy) begin
			rx_active <= 1'b1;
			rx_bit <= '0;
		end
	end

	req_only_when_idle: assert property (@(posedge clk) disable iff (reset) req_latch |-> !busy)
		else $error("pint_link: req_latch while busy");

endmodule

`default_nettype wire

// File: verilog/uart.sv
`timescale 1ns/100ps
`default_nettype none

module uart #(
	parameter int clks_per_bit = ice_pkg::clks_per_bit_default
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        rx_in,
	output logic       tx_out,
	input  wire        tx_latch,
	input  wire  [7:0] tx_data,
	output logic       tx_empty,
	output logic [7:0] rx_data,
	output logic       rx_latch
);

	localparam int cnt_w = $clog2(clks_per_bit);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;

	rx_state_t        rx_state;
	logic             rx_meta;
	logic             rx_sync;
	logic [cnt_w-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	logic [9:0]       tx_shift;
	logic [3:0]       tx_bits;
	logic [cnt_w-1:0] tx_cnt;

	// Line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		rx_latch <= 1'b0;
		if (reset) begin
			rx_state <= rx_idle;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else if (rx_state == rx_idle) begin
			// Half a bit to land in the middle of the start bit
			if (!rx_sync) begin
				rx_cnt <= cnt_w'(clks_per_bit / 2);
				rx_state <= rx_start;
			end
		end else if (rx_cnt != '0) begin
			rx_cnt <= rx_cnt - 1'b1;
		end else begin
			rx_cnt <= cnt_w'(clks_per_bit - 1);
			case (rx_state)
				rx_start: begin
					rx_bit <= '0;
					rx_state <= rx_sync ? rx_idle : rx_bits;
				end
				rx_bits: begin
					// LSB first
					rx_data <= {rx_sync, rx_data[7:1]};
					rx_bit <= rx_bit + 3'd1;
					if (rx_bit == 3'd7)
						rx_state <= rx_stop;
				end
				default: begin
					// Framing error drops the byte
					rx_latch <= rx_sync;
					rx_state <= rx_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_shift <= '1;
			tx_bits <= '0;
			tx_cnt <= '0;
			tx_empty <= 1'b1;
		end else if (tx_latch) begin
			tx_shift <= {1'b1, tx_data, 1'b0};
			tx_bits <= 4'd10;
			tx_cnt <= cnt_w'(clks_per_bit - 1);
			tx_empty <= 1'b0;
		end else if (!tx_empty) begin
			if (tx_cnt != '0) begin
				tx_cnt <= tx_cnt - 1'b1;
			end else begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_cnt <= cnt_w'(clks_per_bit - 1);
				tx_bits <= tx_bits - 4'd1;
				if (tx_bits == 4'd1)
					tx_empty <= 1'b1;
			end
		end
	end

	assign tx_out = tx_shift[0];

endmodule

`default_nettype wire
